//--- verilog/drac_pkg.sv
// ------------------------------------------------
// Shared types and constants for the DRAC register core
// Region and offset codes, ESPM word map, bus structs
// Import with a wildcard in the module header
// ------------------------------------------------

package drac_pkg;

    // Address bits 15:12
    typedef enum logic [3:0] {
        REGION_MAIN  = 4'h0,
        REGION_BOARD = 4'hB,
        REGION_ESPM  = 4'hC
    } region_e;

    // Address bits 3:0 inside the main region
    typedef enum logic [3:0] {
        OFF_ENC_LOAD = 4'd4,
        OFF_ENC_DATA = 4'd5
    } main_off_e;

    typedef enum logic {
        COPY_IDLE,
        COPY_RUN
    } copy_state_e;

    // ---------------- ESPM word map ----------------
    localparam int ESPM_WORDS        = 64;
    localparam int ESPM_POS_BASE     = 8;  // Channel c sits at word 8 + c
    localparam int ESPM_SWITCH_WORD  = 32;
    localparam int ESPM_ESII_WORD    = 33; // Bit 1 comm good, bit 0 ECM
    localparam int ESPM_PRELOAD_WORD = 40;

    localparam int NUM_ENC = 7;
    localparam int ENC_W   = 24;

    // Board region offsets, address bits 11:0
    localparam logic [11:0] BOARD_CRC_ERR  = 12'h000;
    localparam logic [11:0] BOARD_CRC_GOOD = 12'h001;
    localparam logic [11:0] BOARD_MV       = 12'h002;
    localparam logic [11:0] BOARD_ESII     = 12'h010;
    localparam logic [11:0] BOARD_DIGIN    = 12'h021;
    localparam logic [11:0] BOARD_ESPMV_EN = 12'h102;

    localparam logic [31:0] UNMAPPED_DATA = 32'h0000CCCC;

    // One deserialized word, crc_good only meaningful with eof
    typedef struct packed {
        logic        valid;
        logic [5:0]  sel;
        logic [31:0] data;
        logic        eof;
        logic        crc_good;
    } espm_rx_t;

    // Fields pulled out of the committed frame
    typedef struct packed {
        logic [NUM_ENC-1:0][ENC_W-1:0] pos;  // pos[0] is channel 1
        logic [31:0]                   switch_word;
        logic                          esii_good;
        logic                          preload_good;
    } espm_fields_t;

    typedef struct packed {
        logic mv_good;
        logic comm_good;
        logic esii_good;
        logic preload_good;
        logic espmv_en;
    } board_status_t;

endpackage

//--- verilog/apb_reg_slave.sv
// ------------------------------------------------
// APB slave for the DRAC register space
// Fixed one wait state, read data registered in the first
// access cycle, writes land at the edge ending the transfer
// ------------------------------------------------

`timescale 1ns/1ps

module apb_reg_slave
    import drac_pkg::*;
(
    input  logic              sysclk,
    input  logic              rst_n_i,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [15:0]       paddr_i,
    input  logic [31:0]       pwdata_i,
    output logic [31:0]       prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output logic              preload_we_o,
    output logic [2:0]        preload_chan_o,
    output logic [ENC_W-1:0]  preload_data_o,
    input  logic [31:0]       enc_rdata_i,
    output logic [5:0]        espm_raddr_o,
    input  logic [31:0]       espm_rdata_i,
    input  logic [31:0]       crc_good_count_i,
    input  logic [31:0]       crc_err_count_i,
    input  logic [15:0]       mv_i,
    input  espm_fields_t      fields_i,
    input  logic [3:0]        status_i,   // mv, comm, esii, preload
    output logic              espmv_en_o
);

    region_e     region;
    main_off_e   off;
    logic [3:0]  chan;
    logic [11:0] board_off;
    logic        access, first_cyc, last_cyc;
    logic        main_ok, dec_err, wr_en;
    logic [31:0] rd_mux;
    logic        pready_q, pslverr_q, espmv_en_q;
    logic [31:0] prdata_q;

    assign region    = region_e'(paddr_i[15:12]);
    assign off       = main_off_e'(paddr_i[3:0]);
    assign chan      = paddr_i[7:4];
    assign board_off = paddr_i[11:0];

    assign access    = psel_i && penable_i;
    assign first_cyc = access && !pready_q;
    assign last_cyc  = access && pready_q;

    assign main_ok = (chan != 4'd0) && (chan <= 4'd7) &&
                     (off == OFF_ENC_LOAD || off == OFF_ENC_DATA);

    always_comb begin
        case (region)
            REGION_MAIN:  dec_err = !main_ok;
            REGION_BOARD,
            REGION_ESPM:  dec_err = 1'b0;
            default:      dec_err = 1'b1;
        endcase
    end

    // ---------------- Read mux ----------------
    // ESII status comes straight from the committed RAM
    assign espm_raddr_o = (region == REGION_BOARD && board_off == BOARD_ESII) ?
                          6'(ESPM_ESII_WORD) : paddr_i[5:0];

    always_comb begin
        rd_mux = '0;
        case (region)
            REGION_MAIN: rd_mux = enc_rdata_i;  // Load and data offsets read back alike
            REGION_ESPM: rd_mux = espm_rdata_i;
            REGION_BOARD: begin
                case (board_off)
                    BOARD_CRC_ERR:  rd_mux = crc_err_count_i;
                    BOARD_CRC_GOOD: rd_mux = crc_good_count_i;
                    BOARD_MV:       rd_mux = {16'h0000, mv_i};
                    BOARD_ESII:     rd_mux = espm_rdata_i;
                    BOARD_DIGIN:    rd_mux = fields_i.switch_word;
                    BOARD_ESPMV_EN: rd_mux = {27'd0, status_i, espmv_en_q};
                    default:        rd_mux = UNMAPPED_DATA;
                endcase
            end
            default: rd_mux = '0;
        endcase
    end

    // ---------------- Transfer sequencing ----------------
    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= first_cyc;             // Exactly one wait state
            pslverr_q <= first_cyc && dec_err;
        end
    end

    always_ff @(posedge sysclk) begin
        if (first_cyc) begin
            prdata_q <= rd_mux;
        end
    end

    assign wr_en = last_cyc && pwrite_i && !pslverr_q;

    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            espmv_en_q <= 1'b0;
        end else if (wr_en && region == REGION_BOARD && board_off == BOARD_ESPMV_EN) begin
            espmv_en_q <= pwdata_i[0];
        end
    end

    assign preload_we_o   = wr_en && region == REGION_MAIN && off == OFF_ENC_LOAD;
    assign preload_chan_o = paddr_i[6:4];
    assign preload_data_o = pwdata_i[ENC_W-1:0];

    assign prdata_o   = prdata_q;
    assign pready_o   = pready_q;
    assign pslverr_o  = pslverr_q;
    assign espmv_en_o = espmv_en_q;

    // Master must hold the access phase until ready
    a_ready_in_access: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        pready_o |-> (psel_i && penable_i))
        else $error("pready_o high outside an access phase");

endmodule

//--- verilog/espm_frame_buffer.sv
// ------------------------------------------------
// ESPM receive buffer
// Words land in a staging RAM, a good CRC copies the frame
// into the committed RAM and refreshes the extracted fields
// ------------------------------------------------

`timescale 1ns/1ps

module espm_frame_buffer
    import drac_pkg::*;
(
    input  logic         sysclk,
    input  logic         rst_n_i,
    input  espm_rx_t     espm_rx_i,
    input  logic [5:0]   raddr_i,
    output logic [31:0]  rdata_o,
    output espm_fields_t fields_o,
    output logic         good_pulse_o,
    output logic [31:0]  crc_good_count_o,
    output logic [31:0]  crc_err_count_o
);

    logic [31:0] stage_ram  [ESPM_WORDS];
    logic [31:0] commit_ram [ESPM_WORDS];

    copy_state_e  copy_state;
    logic [6:0]   copy_cnt;
    logic         copy_start;
    logic         cp_we;       // Second stage of the copy pipe
    logic [5:0]   cp_addr;
    logic [31:0]  cp_data;
    espm_fields_t fields_q;
    logic         good_eof, bad_eof;

    assign good_eof   = espm_rx_i.eof && espm_rx_i.crc_good;
    assign bad_eof    = espm_rx_i.eof && !espm_rx_i.crc_good;
    assign copy_start = good_eof && copy_state == COPY_IDLE;

    always_ff @(posedge sysclk) begin
        if (espm_rx_i.valid) begin
            stage_ram[espm_rx_i.sel] <= espm_rx_i.data;
        end
    end

    // ---------------- Copy FSM ----------------
    // Read stage, then write commit one cycle later
    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            copy_state <= COPY_IDLE;
            copy_cnt   <= '0;
            cp_we      <= 1'b0;
        end else begin
            case (copy_state)
                COPY_IDLE: begin
                    cp_we    <= 1'b0;
                    copy_cnt <= '0;
                    if (copy_start) begin
                        copy_state <= COPY_RUN;
                    end
                end
                COPY_RUN: begin
                    cp_we    <= !copy_cnt[6];
                    copy_cnt <= copy_cnt + 7'd1;
                    if (copy_cnt == 7'(ESPM_WORDS + 1)) begin
                        copy_state <= COPY_IDLE;
                    end
                end
                default: copy_state <= COPY_IDLE;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        cp_data <= stage_ram[copy_cnt[5:0]];
        cp_addr <= copy_cnt[5:0];
        if (cp_we) begin
            commit_ram[cp_addr] <= cp_data;
        end
    end

    assign rdata_o = commit_ram[raddr_i];

    // ---------------- Field extraction ----------------
    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            fields_q <= '0;
        end else if (cp_we) begin
            if (cp_addr > 6'(ESPM_POS_BASE) && cp_addr <= 6'(ESPM_POS_BASE + NUM_ENC)) begin
                fields_q.pos[cp_addr - 6'(ESPM_POS_BASE + 1)] <= cp_data[ENC_W-1:0];
            end
            if (cp_addr == 6'(ESPM_SWITCH_WORD)) begin
                fields_q.switch_word <= cp_data;
            end
            if (cp_addr == 6'(ESPM_ESII_WORD)) begin
                fields_q.esii_good <= cp_data[1];
            end
            if (cp_addr == 6'(ESPM_PRELOAD_WORD)) begin
                fields_q.preload_good <= cp_data[0];
            end
        end
    end

    assign fields_o = fields_q;

    // Counters see every eof, even one arriving mid-copy
    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            crc_good_count_o <= '0;
            crc_err_count_o  <= '0;
            good_pulse_o     <= 1'b0;
        end else begin
            good_pulse_o <= good_eof;
            if (good_eof) crc_good_count_o <= crc_good_count_o + 32'd1;
            if (bad_eof)  crc_err_count_o  <= crc_err_count_o + 32'd1;
        end
    end

    // A started copy runs its full length without restarting
    a_copy_len: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        copy_start |=> (copy_state == COPY_RUN) [*ESPM_WORDS+2] ##1 (copy_state == COPY_IDLE))
        else $error("ESPM copy restarted or ran the wrong length");

endmodule

//--- verilog/encoder_preload.sv
// ------------------------------------------------
// Encoder preload offsets and readback
// Readback is position plus offset, bit 24 flags overflow
// ------------------------------------------------

`timescale 1ns/1ps

module encoder_preload
    import drac_pkg::*;
(
    input  logic                          sysclk,
    input  logic                          rst_n_i,
    input  logic                          preload_we_i,
    input  logic [2:0]                    preload_chan_i,  // 1 to 7
    input  logic [ENC_W-1:0]              preload_data_i,
    input  logic [NUM_ENC-1:0][ENC_W-1:0] pos_i,
    input  logic [2:0]                    rd_chan_i,
    output logic [31:0]                   rdata_o
);

    logic [ENC_W-1:0]   offset [NUM_ENC];
    logic [ENC_W-1:0]   enc_sum [NUM_ENC];
    logic [NUM_ENC-1:0] overflow;
    logic [2:0]         wr_idx, rd_idx;

    assign wr_idx = preload_chan_i - 3'd1;
    assign rd_idx = rd_chan_i - 3'd1;

    always_comb begin
        for (int i = 0; i < NUM_ENC; i++) begin
            enc_sum[i] = pos_i[i] + offset[i];  // Wraps mod 2^24
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            overflow <= '0;
            for (int i = 0; i < NUM_ENC; i++) begin
                offset[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ENC; i++) begin
                if (preload_we_i && wr_idx == 3'(i)) begin
                    offset[i]   <= preload_data_i - pos_i[i];
                    overflow[i] <= 1'b0;
                end else if (enc_sum[i][ENC_W-1:12] == '0 ||
                             enc_sum[i][ENC_W-1:12] == '1) begin
                    overflow[i] <= 1'b1;  // Sticky until next preload
                end
            end
        end
    end

    // Channel 0 wraps to index 7 and reads as zero
    always_comb begin
        if (rd_idx < 3'(NUM_ENC)) begin
            rdata_o = {7'd0, overflow[rd_idx], enc_sum[rd_idx]};
        end else begin
            rdata_o = '0;
        end
    end

endmodule

//--- verilog/power_monitor.sv
// ------------------------------------------------
// Motor-voltage window check and ESPM comm watchdog
// comm_good is re-evaluated once per WDT_PERIOD cycles
// ------------------------------------------------

`timescale 1ns/1ps

module power_monitor #(
    parameter int WDT_PERIOD   = 491520,
    parameter int MV_NOMINAL   = 36570,
    parameter int MV_TOLERANCE = 3657
) (
    input  logic        sysclk,
    input  logic        rst_n_i,
    input  logic [15:0] mv_i,
    input  logic        mv_valid_i,
    input  logic        good_pulse_i,
    output logic        mv_good_o,
    output logic        comm_good_o
);

    localparam int MV_MIN = MV_NOMINAL - MV_TOLERANCE;
    localparam int MV_MAX = MV_NOMINAL + MV_TOLERANCE;
    localparam int CNT_W  = $clog2(WDT_PERIOD + 1);

    logic [15:0]      mv_q;
    logic [CNT_W-1:0] wdt_cnt;
    logic             seen_good;

    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            mv_q <= '0;             // Zero is outside the window
        end else if (mv_valid_i) begin
            mv_q <= mv_i;
        end
    end

    assign mv_good_o = (int'(mv_q) > MV_MIN) && (int'(mv_q) < MV_MAX);

    // ---------------- Watchdog ----------------
    always_ff @(posedge sysclk) begin
        if (!rst_n_i) begin
            wdt_cnt     <= '0;
            seen_good   <= 1'b0;
            comm_good_o <= 1'b1;
        end else if (wdt_cnt == CNT_W'(WDT_PERIOD - 1)) begin
            wdt_cnt     <= '0;
            comm_good_o <= seen_good || good_pulse_i;
            seen_good   <= 1'b0;
        end else begin
            wdt_cnt <= wdt_cnt + 1'b1;
            if (good_pulse_i) seen_good <= 1'b1;
        end
    end

endmodule

//--- verilog/drac_top.sv
// ------------------------------------------------
// DRAC register and sensor core, single sysclk domain
// APB register access, ESPM frame buffer, encoder preload
// and power monitoring
// ------------------------------------------------

`timescale 1ns/1ps

module drac_top
    import drac_pkg::*;
#(
    parameter int WDT_PERIOD   = 491520,
    parameter int MV_NOMINAL   = 36570,
    parameter int MV_TOLERANCE = 3657
) (
    input  logic          sysclk,
    input  logic          rst_n_i,
    input  logic          psel_i,
    input  logic          penable_i,
    input  logic          pwrite_i,
    input  logic [15:0]   paddr_i,
    input  logic [31:0]   pwdata_i,
    output logic [31:0]   prdata_o,
    output logic          pready_o,
    output logic          pslverr_o,
    input  espm_rx_t      espm_rx_i,
    input  logic [15:0]   mv_i,
    input  logic          mv_valid_i,
    output board_status_t status_o
);

    logic             preload_we;
    logic [2:0]       preload_chan;
    logic [ENC_W-1:0] preload_data;
    logic [31:0]      enc_rdata;
    logic [5:0]       espm_raddr;
    logic [31:0]      espm_rdata;
    logic [31:0]      crc_good_count, crc_err_count;
    logic             good_pulse;
    logic             mv_good, comm_good, espmv_en;
    espm_fields_t     fields;

    assign status_o = '{mv_good:      mv_good,
                        comm_good:    comm_good,
                        esii_good:    fields.esii_good,
                        preload_good: fields.preload_good,
                        espmv_en:     espmv_en};

    apb_reg_slave u_apb (
        .sysclk           (sysclk),
        .rst_n_i          (rst_n_i),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .paddr_i          (paddr_i),
        .pwdata_i         (pwdata_i),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .preload_we_o     (preload_we),
        .preload_chan_o   (preload_chan),
        .preload_data_o   (preload_data),
        .enc_rdata_i      (enc_rdata),
        .espm_raddr_o     (espm_raddr),
        .espm_rdata_i     (espm_rdata),
        .crc_good_count_i (crc_good_count),
        .crc_err_count_i  (crc_err_count),
        .mv_i             (mv_i),
        .fields_i         (fields),
        .status_i         (status_o[4:1]),
        .espmv_en_o       (espmv_en)
    );

    espm_frame_buffer u_espm (
        .sysclk           (sysclk),
        .rst_n_i          (rst_n_i),
        .espm_rx_i        (espm_rx_i),
        .raddr_i          (espm_raddr),
        .rdata_o          (espm_rdata),
        .fields_o         (fields),
        .good_pulse_o     (good_pulse),
        .crc_good_count_o (crc_good_count),
        .crc_err_count_o  (crc_err_count)
    );

    // Readback channel is the same address field as the preload channel
    encoder_preload u_enc (
        .sysclk         (sysclk),
        .rst_n_i        (rst_n_i),
        .preload_we_i   (preload_we),
        .preload_chan_i (preload_chan),
        .preload_data_i (preload_data),
        .pos_i          (fields.pos),
        .rd_chan_i      (preload_chan),
        .rdata_o        (enc_rdata)
    );

    power_monitor #(
        .WDT_PERIOD   (WDT_PERIOD),
        .MV_NOMINAL   (MV_NOMINAL),
        .MV_TOLERANCE (MV_TOLERANCE)
    ) u_pwr (
        .sysclk       (sysclk),
        .rst_n_i      (rst_n_i),
        .mv_i         (mv_i),
        .mv_valid_i   (mv_valid_i),
        .good_pulse_i (good_pulse),
        .mv_good_o    (mv_good),
        .comm_good_o  (comm_good)
    );

endmodule

//--- verif/tb_drac.sv
// --------------------------------------------------
// Self-checking testbench for drac_top
// APB tasks and an ESPM frame generator drive the DUT,
// concurrent assertions compare it with a frame model
// --------------------------------------------------

`timescale 1ns/1ps

module tb_drac
    import drac_pkg::*;
();

    localparam int WDT        = 400;
    localparam int COPY_WAIT  = ESPM_WORDS + 4;  // Commit done 66 cycles after eof
    // About 3000 cycles of tests, twice that as limit
    localparam int MAX_CYCLES = 6000;
    localparam logic [3:0] ENC_CH = 4'd3;

    logic          sysclk;
    logic          rst_n_i;
    logic          psel, penable, pwrite;
    logic [15:0]   paddr;
    logic [31:0]   pwdata, prdata;
    logic          pready, pslverr;
    espm_rx_t      espm_rx;
    logic [15:0]   mv;
    logic          mv_valid;
    board_status_t status;

    // ---------------- Checker controls ----------------
    logic          chk_rd, exp_err;
    logic [31:0]   exp_rdata;
    logic          chk_status;
    board_status_t exp_status, want;
    logic [4:0]    status_mask;

    logic [31:0]   tx_words    [ESPM_WORDS];
    logic [31:0]   model_words [ESPM_WORDS];  // Last good frame
    logic [31:0]   lfsr;
    logic [23:0]   enc_load;
    logic [31:0]   old_pos;
    int            good_sent, bad_sent;
    int            err_cnt, rd_cnt, st_cnt, cyc;

    drac_top #(
        .WDT_PERIOD (WDT)
    ) UUT (
        .sysclk     (sysclk),
        .rst_n_i    (rst_n_i),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr),
        .espm_rx_i  (espm_rx),
        .mv_i       (mv),
        .mv_valid_i (mv_valid),
        .status_o   (status)
    );

    initial sysclk = 1'b0;
    always #10 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, test sequence did not finish", cyc);
            $display("Errors: %0d, reads checked: %0d, status checks: %0d",
                     err_cnt, rd_cnt, st_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ---------------- Assertions ----------------
    // First access cycle is the wait state, ready follows on the next
    a_one_wait: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        (psel && $rose(penable)) |-> (!pready ##1 pready))
        else begin
            err_cnt = err_cnt + 1;
            $display("APB transfer at %h did not end after exactly one wait state",
                     $sampled(paddr));
        end

    a_rd_err: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        (pready && chk_rd) |-> (pslverr == exp_err))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR pslverr_o at %h: exp %h got %h", $sampled(paddr),
                     $sampled(exp_err), $sampled(pslverr));
        end

    a_rd_data: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        (pready && chk_rd && !exp_err) |-> (prdata == exp_rdata))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR prdata_o at %h: exp %h got %h", $sampled(paddr),
                     $sampled(exp_rdata), $sampled(prdata));
        end

    a_status: assert property (@(posedge sysclk) disable iff (!rst_n_i)
        chk_status |-> (((status ^ exp_status) & status_mask) == 5'd0))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR status_o mask %h: exp %h got %h", $sampled(status_mask),
                     $sampled(exp_status), $sampled(status));
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        chk_rd  <= 1'b0;
        @(posedge sysclk);
        penable <= 1'b1;
        @(negedge sysclk);
        while (!pready) @(negedge sysclk);
        @(posedge sysclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, input logic [31:0] data,
                            input logic err);
        @(posedge sysclk);
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= addr;
        exp_rdata <= data;
        exp_err   <= err;
        chk_rd    <= 1'b1;
        @(posedge sysclk);
        penable <= 1'b1;
        @(negedge sysclk);
        while (!pready) @(negedge sysclk);  // Global counter catches a hang
        @(posedge sysclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        chk_rd  <= 1'b0;
        rd_cnt++;
    endtask

    task automatic expect_status(input board_status_t value, input logic [4:0] mask);
        @(posedge sysclk);
        exp_status  <= value;
        status_mask <= mask;
        chk_status  <= 1'b1;
        @(posedge sysclk);
        @(posedge sysclk);
        chk_status <= 1'b0;
        st_cnt++;
    endtask

    // One LFSR step per data bit
    task automatic build_frame();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < ESPM_WORDS; i++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_step(lfsr);
                w    = {w[30:0], lfsr[0]};
            end
            tx_words[i] = w;
        end
    endtask

    task automatic send_frame(input logic crc_ok);
        for (int i = 0; i < ESPM_WORDS; i++) begin
            @(posedge sysclk);
            espm_rx <= '{valid: 1'b1, sel: 6'(i), data: tx_words[i],
                         eof: 1'b0, crc_good: 1'b0};
        end
        @(posedge sysclk);
        espm_rx <= '{valid: 1'b0, sel: 6'd0, data: 32'd0, eof: 1'b1, crc_good: crc_ok};
        @(posedge sysclk);
        espm_rx <= '0;
        if (crc_ok) begin
            model_words = tx_words;
            good_sent++;
        end else begin
            bad_sent++;
        end
        repeat (COPY_WAIT) @(posedge sysclk);
    endtask

    task automatic verify_committed();
        for (int n = 0; n < ESPM_WORDS; n++) begin
            read_reg({4'hC, 6'd0, 6'(n)}, model_words[n], 1'b0);
        end
    endtask

    // Latch one sample, then check mv_good and its readback
    task automatic sample_mv(input logic [15:0] value, input logic exp_good);
        @(posedge sysclk);
        mv       <= value;
        mv_valid <= 1'b1;
        @(posedge sysclk);
        mv_valid <= 1'b0;
        want = '0;
        want.mv_good = exp_good;
        expect_status(want, 5'b10000);
        read_reg({4'hB, BOARD_MV}, {16'h0000, value}, 1'b0);
    endtask

    initial begin
        lfsr      = 32'd98299;
        err_cnt   = 0;
        rd_cnt    = 0;
        st_cnt    = 0;
        cyc       = 0;
        good_sent = 0;
        bad_sent  = 0;
        rst_n_i     <= 1'b0;
        psel        <= 1'b0;
        penable     <= 1'b0;
        pwrite      <= 1'b0;
        paddr       <= '0;
        pwdata      <= '0;
        espm_rx     <= '0;
        mv          <= '0;
        mv_valid    <= 1'b0;
        chk_rd      <= 1'b0;
        exp_err     <= 1'b0;
        exp_rdata   <= '0;
        chk_status  <= 1'b0;
        exp_status  <= '0;
        status_mask <= '0;
        repeat (8) @(posedge sysclk);
        rst_n_i <= 1'b1;

        // Out of reset, comm good until the first watchdog check
        want = '0;
        want.comm_good = 1'b1;
        expect_status(want, 5'b11111);

        // ---------------- Slave error ----------------
        read_reg(16'h3000, 32'd0, 1'b1);
        read_reg({8'h00, 4'd0, OFF_ENC_DATA}, 32'd0, 1'b1);
        read_reg(16'hB0F0, UNMAPPED_DATA, 1'b0);

        // ---------------- Committed buffer ----------------
        build_frame();
        send_frame(1'b1);
        verify_committed();
        build_frame();
        send_frame(1'b0);
        verify_committed();   // Bad CRC leaves the commit alone

        read_reg({4'hB, BOARD_CRC_GOOD}, 32'(good_sent), 1'b0);
        read_reg({4'hB, BOARD_CRC_ERR}, 32'(bad_sent), 1'b0);
        read_reg({4'hB, BOARD_ESII}, model_words[ESPM_ESII_WORD], 1'b0);
        read_reg({4'hB, BOARD_DIGIN}, model_words[ESPM_SWITCH_WORD], 1'b0);
        want = '0;
        want.esii_good    = model_words[ESPM_ESII_WORD][1];
        want.preload_good = model_words[ESPM_PRELOAD_WORD][0];
        expect_status(want, 5'b00110);

        // ---------------- Encoder preload ----------------
        enc_load = 24'h345678;
        write_reg({8'h00, ENC_CH, OFF_ENC_LOAD}, {8'h00, enc_load});
        read_reg({8'h00, ENC_CH, OFF_ENC_DATA}, {8'h00, enc_load}, 1'b0);
        build_frame();
        old_pos = model_words[ESPM_POS_BASE + int'(ENC_CH)];
        tx_words[ESPM_POS_BASE + int'(ENC_CH)] = {old_pos[31:24], old_pos[23:0] + 24'h001234};
        send_frame(1'b1);
        read_reg({8'h00, ENC_CH, OFF_ENC_DATA}, {8'h00, enc_load + 24'h001234}, 1'b0);
        write_reg({8'h00, ENC_CH, OFF_ENC_LOAD}, 32'h0000_0100);
        read_reg({8'h00, ENC_CH, OFF_ENC_DATA}, 32'h0100_0100, 1'b0);

        // ---------------- Motor voltage ----------------
        // Both window edges read as out of range
        sample_mv(16'd36570, 1'b1);
        sample_mv(16'd40226, 1'b1);
        sample_mv(16'd40227, 1'b0);
        sample_mv(16'd32913, 1'b0);

        // ---------------- Power enable and watchdog ----------------
        write_reg({4'hB, BOARD_ESPMV_EN}, 32'd0);
        want = '0;
        expect_status(want, 5'b00001);
        write_reg({4'hB, BOARD_ESPMV_EN}, 32'd1);
        want.espmv_en = 1'b1;
        expect_status(want, 5'b00001);

        repeat (2 * WDT + 20) @(posedge sysclk);
        want = '0;
        expect_status(want, 5'b01000);
        repeat (7) begin       // One frame every ~135 cycles
            build_frame();
            send_frame(1'b1);
        end
        want.comm_good = 1'b1;
        expect_status(want, 5'b01000);
        read_reg({4'hB, BOARD_CRC_GOOD}, 32'(good_sent), 1'b0);
        read_reg({4'hB, BOARD_CRC_ERR}, 32'(bad_sent), 1'b0);

        repeat (4) @(posedge sysclk);
        $display("Errors: %0d, reads checked: %0d, status checks: %0d",
                 err_cnt, rd_cnt, st_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
verilog/drac_pkg.sv
verilog/apb_reg_slave.sv
verilog/espm_frame_buffer.sv
verilog/encoder_preload.sv
verilog/power_monitor.sv
verilog/drac_top.sv
verif/tb_drac.sv

//--- run_sim.sh
#!/bin/sh
# Build and run tb_drac with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_drac -o tb_drac_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_drac_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "No pass verdict in sim.log"; exit 1; }
exit 0
